/* Makefile */
# Verilator build and run for the AES-128 control unit testbench

VERILATOR ?= verilator
TOP       ?= tb_aes_control_unit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
source/aes_host_pkg.sv
source/aes_ctrl_pkg.sv
source/aes_seq_if.sv
source/aes_seq_fsm.sv
source/aes_round_counter.sv
source/aes_ctrl_decoder.sv
source/aes_control_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_aes_control_unit.sv

/* source/aes_control_unit.sv */
/*
 * AES-128 control unit
 * Sequencer FSM, round counter and datapath decoder joined by
 * the sequencer bus, exposed as plain ports
 */
`timescale 1ns/1ps

module aes_control_unit
	import aes_host_pkg::*;
	import aes_ctrl_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               disable_core,
	input  aes_op_e            operation_mode,
	input  aes_chain_e         aes_mode,
	output sbox_sel_e          sbox_sel,
	output rk_sel_e            rk_sel,
	output key_out_sel_e       key_out_sel,
	output col_sel_e           col_sel,
	output key_src_e           key_sel,
	output logic [LANE_W-1:0]  key_en,
	output logic [LANE_W-1:0]  col_en,
	output logic               bypass_rk,
	output logic               bypass_key_en,
	output logic               key_derivation_en,
	output logic [ROUND_W-1:0] round,
	output logic               end_comp,
	output logic               encrypt_decrypt,
	output logic               mode_cbc
);

	// Sequencer bus
	aes_seq_if seq_bus (.clk(clk));

	// State and operation decode
	aes_seq_fsm u_fsm (
		.clk             (clk),
		.rst_n           (rst_n),
		.start           (start),
		.disable_core    (disable_core),
		.operation_mode  (operation_mode),
		.aes_mode        (aes_mode),
		.seq             (seq_bus.fsm),
		.end_comp        (end_comp),
		.encrypt_decrypt (encrypt_decrypt),
		.mode_cbc        (mode_cbc)
	);

	// Round tracking
	aes_round_counter u_counter (
		.clk   (clk),
		.rst_n (rst_n),
		.seq   (seq_bus.counter),
		.round (round)
	);

	// Datapath controls
	aes_ctrl_decoder u_decoder (
		.seq               (seq_bus.decoder),
		.sbox_sel          (sbox_sel),
		.rk_sel            (rk_sel),
		.key_out_sel       (key_out_sel),
		.col_sel           (col_sel),
		.key_sel           (key_sel),
		.key_en            (key_en),
		.col_en            (col_en),
		.bypass_rk         (bypass_rk),
		.bypass_key_en     (bypass_key_en),
		.key_derivation_en (key_derivation_en)
	);

endmodule

/* source/aes_ctrl_decoder.sv */
/*
 * AES datapath decoder
 * Per-state decode of the datapath selects and enables, plus
 * the round counter increment
 */
`timescale 1ns/1ps

module aes_ctrl_decoder
	import aes_ctrl_pkg::*;
(
	aes_seq_if.decoder        seq,
	output sbox_sel_e         sbox_sel,
	output rk_sel_e           rk_sel,
	output key_out_sel_e      key_out_sel,
	output col_sel_e          col_sel,
	output key_src_e          key_sel,
	output logic [LANE_W-1:0] key_en,
	output logic [LANE_W-1:0] col_en,
	output logic              bypass_rk,
	output logic              bypass_key_en,
	output logic              key_derivation_en
);

	logic [1:0] col_idx;
	logic       walk_end;
	logic       cbc_last;

	// One-hot lane enable
	function automatic logic [LANE_W-1:0] lane(input logic [1:0] idx);
		logic [LANE_W-1:0] sel;
		sel      = '0;
		sel[idx] = 1'b1;
		return sel;
	endfunction

	// ============================================================
	// Column index of the current state
	// ============================================================
	always_comb
	begin
		case (seq.state)
			ROUND0_COL1, ROUND_COL1, GEN_KEY1: col_idx = 2'd1;
			ROUND0_COL2, ROUND_COL2, GEN_KEY2: col_idx = 2'd2;
			ROUND0_COL3, ROUND_COL3, GEN_KEY3: col_idx = 2'd3;
			default:                           col_idx = 2'd0;
		endcase
	end

	// Last column of the walk, 3 going up and 0 going down
	assign walk_end = seq.enc_dec ? (col_idx == 2'd3) : (col_idx == 2'd0);

	// Last CBC decryption round takes the chained input
	assign cbc_last = seq.mode_cbc && seq.last_round && !seq.enc_dec;

	// ============================================================
	// Output decode
	// ============================================================
	always_comb
	begin
		sbox_sel          = COL_0;
		rk_sel            = COL;
		key_out_sel       = KEY_0;
		col_sel           = INPUT;
		key_sel           = KEY_HOST;
		key_en            = '0;
		col_en            = '0;
		bypass_rk         = 1'b0;
		bypass_key_en     = 1'b0;
		key_derivation_en = 1'b0;
		seq.round_inc     = 1'b0;
		case (seq.state)
			ROUND0_COL0, ROUND0_COL1, ROUND0_COL2, ROUND0_COL3:
			begin
				// Round 0 adds the key straight to the input
				sbox_sel      = sbox_sel_e'({1'b0, col_idx});
				key_out_sel   = key_out_sel_e'(col_idx);
				bypass_rk     = 1'b1;
				bypass_key_en = 1'b1;
				col_sel       = walk_end ? SHIFT_ROWS : ADD_RK_OUT;
				col_en        = walk_end ? '1 : lane(col_idx);
				// Decryption reloads key words 1..3 from the key output
				if (!seq.enc_dec && (col_idx != 2'd0))
				begin
					key_sel = KEY_OUT;
					key_en  = lane(col_idx);
				end
			end
			ROUND_KEY0:
			begin
				sbox_sel      = G_FUNCTION;
				key_sel       = KEY_OUT;
				key_en        = lane(2'd0);
				seq.round_inc = 1'b1;
			end
			ROUND_COL0, ROUND_COL1, ROUND_COL2, ROUND_COL3:
			begin
				sbox_sel    = sbox_sel_e'({1'b0, col_idx});
				key_out_sel = key_out_sel_e'(col_idx);
				key_sel     = KEY_OUT;
				// No MixColumns in the last round
				rk_sel      = seq.last_round ? MIXCOL_IN : MIXCOL_OUT;
				// Key words trail the column going up, track it going down
				if (seq.enc_dec && (col_idx != 2'd3))
					key_en = lane(col_idx + 2'd1);
				else if (!seq.enc_dec && (col_idx != 2'd0))
					key_en = lane(col_idx);
				if (cbc_last)
					col_sel = INPUT;
				else if (walk_end && !seq.last_round)
					col_sel = SHIFT_ROWS;
				else
					col_sel = ADD_RK_OUT;
				col_en = (walk_end && !seq.last_round) ? '1 : lane(col_idx);
			end
			GEN_KEY0:
			begin
				sbox_sel      = G_FUNCTION;
				seq.round_inc = 1'b1;
			end
			GEN_KEY1, GEN_KEY2, GEN_KEY3:
			begin
				// Word 0 is written together with word 1
				key_en        = (seq.state == GEN_KEY1) ? (lane(2'd0) | lane(2'd1)) : lane(col_idx);
				key_sel       = KEY_OUT;
				bypass_key_en = 1'b1;
			end
			READY:
				key_derivation_en = seq.op_key_derivation;
			default:
			begin
			end
		endcase
	end

	// Datapath columns stay frozen while idle
	assert property (@(posedge seq.clk) (seq.state == IDLE) |-> (col_en == '0));

endmodule

/* source/aes_ctrl_pkg.sv */
/*
 * AES-128 controller, datapath-side definitions
 * Sequencer states and the select codes driven into the
 * column-serial datapath
 */
package aes_ctrl_pkg;

	// ============================================================
	// Sequencer states
	// ============================================================
	typedef enum logic [3:0] {
		IDLE        = 4'd0,
		// Initial key addition, one column per cycle
		ROUND0_COL0 = 4'd1,
		ROUND0_COL1 = 4'd2,
		ROUND0_COL2 = 4'd3,
		ROUND0_COL3 = 4'd4,
		// Round key step through the G function
		ROUND_KEY0  = 4'd5,
		ROUND_COL0  = 4'd6,
		ROUND_COL1  = 4'd7,
		ROUND_COL2  = 4'd8,
		ROUND_COL3  = 4'd9,
		READY       = 4'd10,
		// Key schedule walk
		GEN_KEY0    = 4'd11,
		GEN_KEY1    = 4'd12,
		GEN_KEY2    = 4'd13,
		GEN_KEY3    = 4'd14,
		// Bubble between round key and next round
		NOP         = 4'd15
	} seq_state_e;

	// ============================================================
	// Datapath selects
	// ============================================================
	// S-box input source
	typedef enum logic [2:0] {
		COL_0      = 3'b000,
		COL_1      = 3'b001,
		COL_2      = 3'b010,
		COL_3      = 3'b011,
		G_FUNCTION = 3'b100
	} sbox_sel_e;

	// Round-key adder input
	typedef enum logic [1:0] {
		COL        = 2'b00,
		MIXCOL_IN  = 2'b01,
		MIXCOL_OUT = 2'b10
	} rk_sel_e;

	// Key word on the key output bus
	typedef enum logic [1:0] {
		KEY_0 = 2'b00,
		KEY_1 = 2'b01,
		KEY_2 = 2'b10,
		KEY_3 = 2'b11
	} key_out_sel_e;

	// Column register load source
	typedef enum logic [1:0] {
		SHIFT_ROWS = 2'b00,
		ADD_RK_OUT = 2'b01,
		INPUT      = 2'b10
	} col_sel_e;

	// Key register load source
	typedef enum logic {
		KEY_HOST = 1'b0,
		KEY_OUT  = 1'b1
	} key_src_e;

	// One enable per column and per key word
	localparam int LANE_W = 4;

endpackage

/* source/aes_host_pkg.sv */
/*
 * AES-128 controller, host-side definitions
 * Operation and chaining-mode codes as written by the host,
 * and the round-count limits of the key schedule
 */
package aes_host_pkg;

	// ============================================================
	// Operations requested by the host
	// ============================================================
	typedef enum logic [1:0] {
		ENCRYPTION     = 2'b00,
		KEY_DERIVATION = 2'b01,
		DECRYPTION     = 2'b10,
		// Derive the last round key, then decrypt
		DECRYP_W_DERIV = 2'b11
	} aes_op_e;

	// ============================================================
	// Chaining modes
	// ============================================================
	typedef enum logic [1:0] {
		ECB = 2'b00,
		CBC = 2'b01,
		// Code kept reserved, no counter mode in this core
		CTR = 2'b10
	} aes_chain_e;

	// ============================================================
	// Round counting
	// ============================================================
	// Width of the round number
	localparam int ROUND_W = 4;

	// Last round of AES-128
	localparam logic [ROUND_W-1:0] NUM_ROUNDS = 4'd10;

	// Decryption bumps the count once more on its final key step
	localparam logic [ROUND_W-1:0] NUM_ROUNDS_INC = 4'd11;

endpackage

/* source/aes_round_counter.sv */
/*
 * AES round counter
 * Counts round key steps and flags the first and last round
 */
`timescale 1ns/1ps

module aes_round_counter
	import aes_host_pkg::*;
	import aes_ctrl_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	aes_seq_if.counter         seq,
	output logic [ROUND_W-1:0] round
);

	logic [ROUND_W-1:0] rd_count;

	// ============================================================
	// Counter
	// ============================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_count <= '0;
		// Restart in IDLE and when the key schedule hands over to decryption
		else if ((seq.state == IDLE) || ((seq.state == GEN_KEY3) && seq.last_round))
			rd_count <= '0;
		else if (seq.round_inc)
			rd_count <= rd_count + 1'b1;
	end

	assign round = rd_count;

	// Round flags
	assign seq.first_round = (rd_count == '0);
	// 11 is reached only by the last decryption key step
	assign seq.last_round  = (rd_count == NUM_ROUNDS) || (rd_count == NUM_ROUNDS_INC);

	// Sequencer must leave the rounds before the count runs past 11
	assert property (@(posedge clk) disable iff (!rst_n) rd_count <= NUM_ROUNDS_INC);

endmodule

/* source/aes_seq_fsm.sv */
/*
 * AES sequencer FSM
 * Decodes the host operation, holds the state register and
 * walks the columns up for encryption and down for decryption
 */
`timescale 1ns/1ps

module aes_seq_fsm
	import aes_host_pkg::*;
	import aes_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  logic       disable_core,
	input  aes_op_e    operation_mode,
	input  aes_chain_e aes_mode,
	aes_seq_if.fsm     seq,
	output logic       end_comp,
	output logic       encrypt_decrypt,
	output logic       mode_cbc
);

	seq_state_e state;
	seq_state_e next_state;
	logic       enc_dec;

	// ============================================================
	// Operation decode
	// ============================================================
	// Key schedule always runs in the forward direction
	assign enc_dec = (operation_mode == ENCRYPTION) || (operation_mode == KEY_DERIVATION) ||
		(state inside {GEN_KEY0, GEN_KEY1, GEN_KEY2, GEN_KEY3});

	assign mode_cbc               = (aes_mode == CBC);
	assign encrypt_decrypt        = enc_dec;
	assign seq.enc_dec            = enc_dec;
	assign seq.mode_cbc           = mode_cbc;
	assign seq.op_key_derivation  = (operation_mode == KEY_DERIVATION);
	assign seq.state              = state;

	// ============================================================
	// State flops
	// ============================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else if (disable_core)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Next state
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				// Start only counts here
				if (start)
				begin
					case (operation_mode)
						ENCRYPTION:     next_state = ROUND0_COL0;
						DECRYPTION:     next_state = ROUND0_COL3;
						default:        next_state = GEN_KEY0;
					endcase
				end
			end
			ROUND0_COL0: next_state = enc_dec ? ROUND0_COL1 : ROUND_KEY0;
			ROUND0_COL1: next_state = enc_dec ? ROUND0_COL2 : ROUND0_COL0;
			ROUND0_COL2: next_state = enc_dec ? ROUND0_COL3 : ROUND0_COL1;
			ROUND0_COL3: next_state = enc_dec ? ROUND_KEY0 : ROUND0_COL2;
			ROUND_KEY0:
			begin
				// After round 0 go straight into the first round
				if (seq.first_round)
					next_state = enc_dec ? ROUND_COL0 : ROUND_COL3;
				else
					next_state = seq.last_round ? READY : NOP;
			end
			NOP:         next_state = enc_dec ? ROUND_COL0 : ROUND_COL3;
			ROUND_COL0:  next_state = enc_dec ? ROUND_COL1 : ROUND_KEY0;
			ROUND_COL1:  next_state = enc_dec ? ROUND_COL2 : ROUND_COL0;
			ROUND_COL2:  next_state = enc_dec ? ROUND_COL3 : ROUND_COL1;
			ROUND_COL3:
			begin
				// Encryption ends on its last column
				if (enc_dec)
					next_state = seq.last_round ? READY : ROUND_KEY0;
				else
					next_state = ROUND_COL2;
			end
			GEN_KEY0:    next_state = GEN_KEY1;
			GEN_KEY1:    next_state = GEN_KEY2;
			GEN_KEY2:    next_state = GEN_KEY3;
			GEN_KEY3:
			begin
				// Derivation alone stops here, otherwise decrypt from column 3
				if (!seq.last_round)
					next_state = GEN_KEY0;
				else
					next_state = seq.op_key_derivation ? READY : ROUND0_COL3;
			end
			READY:       next_state = IDLE;
			default:     next_state = IDLE;
		endcase
	end

	// Done pulse
	assign end_comp = (state == READY);

	// READY always falls back to IDLE
	assert property (@(posedge clk) disable iff (!rst_n) end_comp |=> !end_comp);

endmodule

/* source/aes_seq_if.sv */
/*
 * Sequencer bus
 * Carries the state and decoded operation from the FSM and
 * the round status from the counter to the datapath decoder
 */
`timescale 1ns/1ps

interface aes_seq_if
	import aes_ctrl_pkg::*;
(
	input logic clk
);

	seq_state_e state;
	// High while encrypting or walking the key schedule
	logic enc_dec;
	logic op_key_derivation;
	logic mode_cbc;

	// Round status
	logic first_round;
	logic last_round;
	logic round_inc;

	modport fsm (
		output state, enc_dec, op_key_derivation, mode_cbc,
		input first_round, last_round
	);

	modport counter (
		input state, round_inc,
		output first_round, last_round
	);

	modport decoder (
		input clk, state, enc_dec, op_key_derivation, mode_cbc, last_round,
		output round_inc
	);

endinterface

/* testbench/tb_aes_control_unit.sv */
/*
 * AES-128 control unit testbench
 * Directed tests for reset, ECB encryption, key derivation,
 * CBC decryption with derivation, core disable and a held start.
 * Inputs change on the rising edge, outputs are sampled on the falling edge
 */
`timescale 1ns/1ps

module tb_aes_control_unit
	import aes_host_pkg::*;
	import aes_ctrl_pkg::*;
();

	// ============================================================
	// Bounds
	// ============================================================
	// Cycles allowed for one operation to reach end_comp
	localparam int OP_BOUND      = 200;
	localparam int IDLE_WATCH    = 16;
	localparam int DISABLE_DELAY = 20;
	localparam int BUSY_OPS      = 3;
	// Sum over all tests, with slack for the idle checks after each pulse
	localparam int TOTAL_BOUND   = IDLE_WATCH + 3 * (OP_BOUND + 24) +
		(DISABLE_DELAY + OP_BOUND + 4) + (BUSY_OPS * OP_BOUND + 8);
	localparam int WATCHDOG_CYCLES = 4 * TOTAL_BOUND;

	logic               clk;
	logic               rst_n;
	logic               start;
	logic               disable_core;
	aes_op_e            operation_mode;
	aes_chain_e         aes_mode;
	sbox_sel_e          sbox_sel;
	rk_sel_e            rk_sel;
	key_out_sel_e       key_out_sel;
	col_sel_e           col_sel;
	key_src_e           key_sel;
	logic [LANE_W-1:0]  key_en;
	logic [LANE_W-1:0]  col_en;
	logic               bypass_rk;
	logic               bypass_key_en;
	logic               key_derivation_en;
	logic [ROUND_W-1:0] round;
	logic               end_comp;
	logic               encrypt_decrypt;
	logic               mode_cbc;

	int mismatch_count = 0;
	int failure_count  = 0;

	tb_clock_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	aes_control_unit u_dut (
		.clk               (clk),
		.rst_n             (rst_n),
		.start             (start),
		.disable_core      (disable_core),
		.operation_mode    (operation_mode),
		.aes_mode          (aes_mode),
		.sbox_sel          (sbox_sel),
		.rk_sel            (rk_sel),
		.key_out_sel       (key_out_sel),
		.col_sel           (col_sel),
		.key_sel           (key_sel),
		.key_en            (key_en),
		.col_en            (col_en),
		.bypass_rk         (bypass_rk),
		.bypass_key_en     (bypass_key_en),
		.key_derivation_en (key_derivation_en),
		.round             (round),
		.end_comp          (end_comp),
		.encrypt_decrypt   (encrypt_decrypt),
		.mode_cbc          (mode_cbc)
	);

	// ============================================================
	// Reporting helpers
	// ============================================================
	task automatic report_mismatch(input string msg);
		mismatch_count++;
		$display("MISMATCH at %0t ns: %s", $time, msg);
	endtask

	task automatic report_failure(input string msg);
		failure_count++;
		$display("FAILURE at %0t ns: %s", $time, msg);
	endtask

	task automatic print_error_counts();
		$display("Error counts: %0d mismatches, %0d other failures", mismatch_count,
			failure_count);
	endtask

	// Idle values of the datapath controls
	task automatic expect_idle_outputs(input string where);
		if (end_comp !== 1'b0)
			report_mismatch({where, ": end_comp high"});
		if (key_en !== '0)
			report_mismatch($sformatf("%s: key_en = %b, expected 0", where, key_en));
		if (col_en !== '0)
			report_mismatch($sformatf("%s: col_en = %b, expected 0", where, col_en));
		if (key_derivation_en !== 1'b0)
			report_mismatch({where, ": key_derivation_en high"});
		if (bypass_rk !== 1'b0)
			report_mismatch({where, ": bypass_rk high"});
		if (bypass_key_en !== 1'b0)
			report_mismatch({where, ": bypass_key_en high"});
	endtask

	// Selects that follow the column or key word being written
	task automatic check_write_selects(input string where);
		int                written_col;
		logic [LANE_W-1:0] one_hot;
		rk_sel_e           rk_expected;
		written_col = -1;
		for (int i = 0; i < LANE_W; i++)
		begin
			one_hot    = '0;
			one_hot[i] = 1'b1;
			if (col_en === one_hot)
				written_col = i;
		end
		// Column i adds key word i
		if ((written_col >= 0) && (key_out_sel !== key_out_sel_e'(written_col)))
			report_mismatch($sformatf("%s: key_out_sel = %0d while column %0d is written",
				where, key_out_sel, written_col));
		// Final round skips MixColumns
		if ((col_en !== '0) && (bypass_rk === 1'b0))
		begin
			rk_expected = (round === NUM_ROUNDS) ? MIXCOL_IN : MIXCOL_OUT;
			if (rk_sel !== rk_expected)
				report_mismatch($sformatf("%s: rk_sel = %0d in round %0d, expected %0d",
					where, rk_sel, round, rk_expected));
		end
		// Key words reload from the key schedule output
		if ((key_en !== '0) && (key_sel !== KEY_OUT))
			report_mismatch($sformatf("%s: key_sel = %0d on a key write, expected KEY_OUT",
				where, key_sel));
	endtask

	// One-cycle start, sampled by the DUT on the following edge
	task automatic launch_operation(input aes_op_e op, input aes_chain_e mode);
		@(posedge clk);
		operation_mode <= op;
		aes_mode       <= mode;
		start          <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Pulse must not repeat once the FSM is back in IDLE
	task automatic expect_no_more_pulses(input int cycles, input string where);
		repeat (cycles)
		begin
			@(negedge clk);
			if (end_comp !== 1'b0)
				report_mismatch({where, ": extra end_comp pulse"});
		end
	endtask

	// ============================================================
	// Tests
	// ============================================================
	task automatic check_reset_values();
		repeat (IDLE_WATCH)
		begin
			@(negedge clk);
			expect_idle_outputs("after reset");
			if (round !== '0)
				report_mismatch($sformatf("after reset: round = %0d, expected 0", round));
		end
	endtask

	task automatic run_ecb_encryption();
		int cycles;
		bit pulsed;
		bit last_seen;
		cycles    = 0;
		pulsed    = 0;
		last_seen = 0;
		launch_operation(ENCRYPTION, ECB);
		while (!pulsed && (cycles < OP_BOUND))
		begin
			@(negedge clk);
			cycles++;
			check_write_selects("ECB encryption");
			if (encrypt_decrypt !== 1'b1)
				report_mismatch("ECB encryption: encrypt_decrypt low");
			if (key_derivation_en !== 1'b0)
				report_mismatch("ECB encryption: key_derivation_en high");
			if (end_comp === 1'b1)
				pulsed = 1;
			else if (round === NUM_ROUNDS)
				last_seen = 1;
		end
		if (!pulsed)
		begin
			report_failure("ECB encryption gave no end_comp within the cycle bound");
		end
		else
		begin
			if (!last_seen)
				report_mismatch("ECB encryption: round never reached NUM_ROUNDS before end_comp");
			@(negedge clk);
			expect_idle_outputs("one cycle after ECB end_comp");
			// Counter clears on its first IDLE cycle
			@(negedge clk);
			if (round !== '0)
				report_mismatch($sformatf("after ECB: round = %0d, expected 0", round));
			expect_no_more_pulses(20, "after ECB");
		end
	endtask

	task automatic run_key_derivation();
		int cycles;
		bit pulsed;
		bit g_seen;
		bit last_seen;
		cycles    = 0;
		pulsed    = 0;
		g_seen    = 0;
		last_seen = 0;
		launch_operation(KEY_DERIVATION, ECB);
		while (!pulsed && (cycles < OP_BOUND))
		begin
			@(negedge clk);
			cycles++;
			check_write_selects("key derivation");
			if (sbox_sel === G_FUNCTION)
				g_seen = 1;
			if (round === NUM_ROUNDS)
				last_seen = 1;
			if (end_comp === 1'b1)
			begin
				pulsed = 1;
				if (key_derivation_en !== 1'b1)
					report_mismatch("key derivation: key_derivation_en low with end_comp");
			end
			else if (key_derivation_en !== 1'b0)
			begin
				report_mismatch("key derivation: key_derivation_en high without end_comp");
			end
		end
		if (!pulsed)
		begin
			report_failure("key derivation gave no end_comp within the cycle bound");
		end
		else
		begin
			if (!g_seen)
				report_mismatch("key derivation: sbox_sel never took G_FUNCTION");
			if (!last_seen)
				report_mismatch("key derivation: round never reached NUM_ROUNDS");
			@(negedge clk);
			expect_idle_outputs("one cycle after key derivation end_comp");
			expect_no_more_pulses(4, "after key derivation");
		end
	endtask

	task automatic run_cbc_decrypt_with_derivation();
		int cycles;
		int keygen_cycles;
		bit pulsed;
		bit in_keygen;
		bit input_seen;
		cycles        = 0;
		keygen_cycles = 0;
		pulsed        = 0;
		in_keygen     = 1;
		input_seen    = 0;
		launch_operation(DECRYP_W_DERIV, CBC);
		while (!pulsed && (cycles < OP_BOUND))
		begin
			@(negedge clk);
			cycles++;
			check_write_selects("CBC decrypt");
			// Key generation ends where round 0 starts bypassing the round key
			if (bypass_rk === 1'b1)
				in_keygen = 0;
			if (in_keygen)
			begin
				keygen_cycles++;
				if (encrypt_decrypt !== 1'b1)
					report_mismatch("CBC decrypt: encrypt_decrypt low during key generation");
			end
			else if (encrypt_decrypt !== 1'b0)
			begin
				report_mismatch("CBC decrypt: encrypt_decrypt high after key generation");
			end
			if (mode_cbc !== 1'b1)
				report_mismatch("CBC decrypt: mode_cbc low");
			// Chained input written into a column
			if ((end_comp !== 1'b1) && (col_en !== '0) && (col_sel === INPUT))
				input_seen = 1;
			if (end_comp === 1'b1)
				pulsed = 1;
		end
		if (!pulsed)
		begin
			report_failure("CBC decryption with derivation gave no end_comp within the bound");
		end
		else
		begin
			if (keygen_cycles == 0)
				report_mismatch("CBC decrypt: no key generation cycle seen");
			if (in_keygen)
				report_mismatch("CBC decrypt: decryption rounds never started");
			if (!input_seen)
				report_mismatch("CBC decrypt: col_sel never INPUT on a column write");
			@(negedge clk);
			expect_idle_outputs("one cycle after CBC decrypt end_comp");
			expect_no_more_pulses(20, "after CBC decrypt");
		end
	endtask

	task automatic abort_with_disable();
		launch_operation(ENCRYPTION, ECB);
		repeat (DISABLE_DELAY) @(negedge clk);
		if (round === '0)
			report_failure("encryption not in progress before disable_core");
		@(posedge clk);
		disable_core <= 1'b1;
		@(posedge clk);
		disable_core <= 1'b0;
		@(negedge clk);
		if (col_en !== '0)
			report_mismatch($sformatf("after disable: col_en = %b, expected 0", col_en));
		if (key_en !== '0)
			report_mismatch($sformatf("after disable: key_en = %b, expected 0", key_en));
		// Counter clears once the state is IDLE
		@(negedge clk);
		if (round !== '0)
			report_mismatch($sformatf("after disable: round = %0d, expected 0", round));
		expect_no_more_pulses(OP_BOUND, "after disable");
	endtask

	task automatic hold_start_while_busy();
		int cycles;
		int pulses;
		int pulse_at [BUSY_OPS];
		cycles = 0;
		pulses = 0;
		@(posedge clk);
		operation_mode <= ENCRYPTION;
		aes_mode       <= ECB;
		start          <= 1'b1;
		while ((pulses < BUSY_OPS) && (cycles < BUSY_OPS * OP_BOUND))
		begin
			@(negedge clk);
			cycles++;
			if (end_comp === 1'b1)
			begin
				pulse_at[pulses] = cycles;
				pulses++;
			end
		end
		@(posedge clk);
		start <= 1'b0;
		if (pulses != BUSY_OPS)
		begin
			report_failure($sformatf("held start: %0d end_comp pulses, expected %0d", pulses,
				BUSY_OPS));
		end
		else
		begin
			// One IDLE cycle per restart, so each period equals the first latency
			for (int i = 1; i < BUSY_OPS; i++)
			begin
				if ((pulse_at[i] - pulse_at[i-1]) != pulse_at[0])
					report_mismatch($sformatf("held start: period %0d, expected %0d",
						pulse_at[i] - pulse_at[i-1], pulse_at[0]));
			end
		end
		repeat (2) @(negedge clk);
		expect_idle_outputs("after held start released");
		expect_no_more_pulses(4, "after held start released");
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial
	begin
		start          = 1'b0;
		disable_core   = 1'b0;
		operation_mode = ENCRYPTION;
		aes_mode       = ECB;
		wait (rst_n === 1'b1);
		check_reset_values();
		run_ecb_encryption();
		run_key_derivation();
		run_cbc_decrypt_with_derivation();
		abort_with_disable();
		hold_start_while_busy();
		print_error_counts();
		if ((mismatch_count + failure_count) == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
		print_error_counts();
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* testbench/tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * 20 ns clock, active-low reset held for the first 8 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD  = 10;
	localparam int RESET_CYCLES = 8;

	// Free-running clock
	initial
	begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Reset released on a rising edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule
